// File: src/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // instruction and memory widths, fixed by rv32c and the line size
    localparam int ADDR_W   = 32;
    localparam int LINE_W   = 64;
    localparam int PARCEL_W = 16;
    localparam int INST_W   = 32;

    // bytes per memory line and the pc bits that index into it
    localparam int LINE_BYTES = LINE_W / 8;
    localparam int OFFSET_W   = $clog2(LINE_BYTES);

    // byte address of an instruction or a line
    typedef logic [ADDR_W-1:0]   addr_t;
    // one memory line, four halfword parcels
    typedef logic [LINE_W-1:0]   line_t;
    // one 16-bit instruction parcel
    typedef logic [PARCEL_W-1:0] parcel_t;
    // extracted instruction, compressed ones zero-extended
    typedef logic [INST_W-1:0]   inst_t;
    // byte offset of the pc inside a line
    typedef logic [OFFSET_W-1:0] offset_t;

    // addi x0, x0, 0
    localparam inst_t INST_NOP = 32'h0000_0013;

    // read controller states
    typedef enum logic [1:0] {
        IDLE,
        REFILL_WAIT,
        PREFETCH_WAIT,
        DRAIN
    } fetch_state_e;

endpackage

`default_nettype wire

// File: src/fetch_line_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_line_buffer (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     flush_i,
    input  wire  fetch_pkg::addr_t  pc_i,
    input  wire                     fill_lo_i,
    input  wire                     fill_hi_i,
    input  wire  fetch_pkg::addr_t  fill_base_i,
    input  wire  fetch_pkg::line_t  fill_data_i,
    output logic [63:0]             line0_o,
    output logic [63:0]             line1_o,
    output logic                    line1_valid_o,
    output logic [31:0]             base_o,
    output logic                    hit_o,
    output logic                    miss_o
);

    import fetch_pkg::*;

    // window storage, low line at base_q, high line right after it
    line_t line0_q;
    line_t line1_q;
    logic  line0_valid_q;
    logic  line1_valid_q;
    addr_t base_q;

    addr_t next_base;
    logic  in_lo;
    logic  in_hi;
    logic  shift_dn;

    // line address of the high half of the window
    assign next_base = base_q + addr_t'(LINE_BYTES);

    // compare line numbers only, offset bits ignored
    assign in_lo = pc_i[ADDR_W-1:OFFSET_W] == base_q[ADDR_W-1:OFFSET_W];
    assign in_hi = pc_i[ADDR_W-1:OFFSET_W] == next_base[ADDR_W-1:OFFSET_W];

    assign hit_o    = line0_valid_q && in_lo;
    // sequential walk into the high line, move it down
    assign shift_dn = line1_valid_q && in_hi && !hit_o;
    // nothing buffered for this pc, controller must refill
    assign miss_o   = !hit_o && !shift_dn;

    assign line0_o       = line0_q;
    assign line1_o       = line1_q;
    assign line1_valid_o = line1_valid_q;
    assign base_o        = base_q;

    // line payload
    always_ff @(posedge clk) begin
        if (fill_lo_i) begin
            line0_q <= fill_data_i;
        end else if (shift_dn) begin
            line0_q <= line1_q;
        end
        if (fill_hi_i) begin
            line1_q <= fill_data_i;
        end
    end

    // valid bits and base
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            line0_valid_q <= 1'b0;
            line1_valid_q <= 1'b0;
            base_q        <= '0;
        end else if (flush_i) begin
            // redirect, whole window is stale
            line0_valid_q <= 1'b0;
            line1_valid_q <= 1'b0;
        end else if (fill_lo_i) begin
            // new low line, old high line no longer follows it
            line0_valid_q <= 1'b1;
            line1_valid_q <= 1'b0;
            base_q        <= fill_base_i;
        end else if (shift_dn) begin
            // high line becomes low, high slot empty until prefetch
            base_q        <= next_base;
            line1_valid_q <= 1'b0;
        end else if (fill_hi_i) begin
            line1_valid_q <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: src/fetch_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_ctrl (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     flush_i,
    input  wire  fetch_pkg::addr_t  pc_i,
    input  wire                     miss_i,
    input  wire                     fill_want_hi_i,
    input  wire                     misaligned_i,
    input  wire                     mem_rvalid_i,
    input  wire  fetch_pkg::line_t  mem_rdata_i,
    input  wire  fetch_pkg::addr_t  base_i,
    output logic                    mem_req_o,
    output logic [31:0]             mem_addr_o,
    output logic                    fill_lo_o,
    output logic                    fill_hi_o,
    output logic [31:0]             fill_base_o
);

    import fetch_pkg::*;

    fetch_state_e state_q;

    addr_t pc_line;
    addr_t next_line;
    addr_t chain_line;
    logic  rsp_ok;
    logic  chain_pf;

    // line holding the pc
    assign pc_line    = {pc_i[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    // line after the low line of the window
    assign next_line  = base_i + addr_t'(LINE_BYTES);
    // line after the one being read now
    assign chain_line = mem_addr_o + addr_t'(LINE_BYTES);

    // a response during a flush is already stale
    assign rsp_ok = mem_rvalid_i && !flush_i;

    // refill data holds a 32-bit start in its top parcel at the pc,
    // so the next line is needed straight away
    assign chain_pf = (&pc_i[OFFSET_W-1:1])
                   && (pc_line == mem_addr_o)
                   && (mem_rdata_i[LINE_W-PARCEL_W +: 2] == 2'b11);

    // fills are steered by the state the response arrives in
    assign fill_lo_o   = (state_q == REFILL_WAIT) && rsp_ok;
    assign fill_hi_o   = (state_q == PREFETCH_WAIT) && rsp_ok;
    // address of the outstanding read doubles as the new base
    assign fill_base_o = mem_addr_o;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q    <= IDLE;
            mem_req_o  <= 1'b0;
            mem_addr_o <= '0;
        end else begin
            // request is a single-cycle pulse
            mem_req_o <= 1'b0;
            case (state_q)
                IDLE: begin
                    // odd pc or redirect cycle, no decision
                    if (!flush_i && !misaligned_i) begin
                        if (miss_i) begin
                            mem_req_o  <= 1'b1;
                            mem_addr_o <= pc_line;
                            state_q    <= REFILL_WAIT;
                        end else if (fill_want_hi_i) begin
                            mem_req_o  <= 1'b1;
                            mem_addr_o <= next_line;
                            state_q    <= PREFETCH_WAIT;
                        end
                    end
                end
                REFILL_WAIT: begin
                    if (flush_i) begin
                        // response in this cycle is dropped, else drain it later
                        state_q <= mem_rvalid_i ? IDLE : DRAIN;
                    end else if (mem_rvalid_i) begin
                        if (chain_pf) begin
                            mem_req_o  <= 1'b1;
                            mem_addr_o <= chain_line;
                            state_q    <= PREFETCH_WAIT;
                        end else begin
                            state_q <= IDLE;
                        end
                    end
                end
                PREFETCH_WAIT: begin
                    if (flush_i) begin
                        state_q <= mem_rvalid_i ? IDLE : DRAIN;
                    end else if (mem_rvalid_i) begin
                        state_q <= IDLE;
                    end
                end
                DRAIN: begin
                    // swallow the stale response, no fill
                    if (mem_rvalid_i) begin
                        state_q <= IDLE;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/inst_aligner.sv
`timescale 1ns/10ps
`default_nettype none

module inst_aligner (
    input  wire                     clk_unused_guard_n,
    input  wire  fetch_pkg::addr_t  pc_i,
    input  wire                     hit_i,
    input  wire  fetch_pkg::line_t  line0_i,
    input  wire  fetch_pkg::line_t  line1_i,
    input  wire                     line1_valid_i,
    output logic [31:0]             inst_o,
    output logic                    compressed_o,
    output logic                    stall_o,
    output logic                    fill_want_hi_o,
    output logic                    misaligned_o
);

    import fetch_pkg::*;

    offset_t off;
    parcel_t cur_parcel;
    parcel_t nxt_parcel;
    logic    is_comp;
    logic    spans;
    logic    leaves_lo;

    // byte offset of the pc in the low line
    assign off = pc_i[OFFSET_W-1:0];

    // parcel at the pc and the parcel right after it
    always_comb begin
        case (off[2:1])
            2'd0: begin
                cur_parcel = line0_i[15:0];
                nxt_parcel = line0_i[31:16];
            end
            2'd1: begin
                // 32-bit at offset 2 stays inside the low line
                cur_parcel = line0_i[31:16];
                nxt_parcel = line0_i[47:32];
            end
            2'd2: begin
                cur_parcel = line0_i[47:32];
                nxt_parcel = line0_i[63:48];
            end
            default: begin
                cur_parcel = line0_i[63:48];
                // upper half lives in the high line
                nxt_parcel = line1_i[15:0];
            end
        endcase
    end

    // rvc parcels never have both low bits set
    assign is_comp   = cur_parcel[1:0] != 2'b11;
    // 32-bit instruction crossing into the high line
    assign spans     = !is_comp && (off[2:1] == 2'b11);
    // next sequential pc falls into the high line
    assign leaves_lo = (off[2:1] == 2'b11) || (!is_comp && (off[2:1] == 2'b10));

    assign misaligned_o = pc_i[0];

    // odd pc is flagged and never stalled
    assign stall_o = !misaligned_o && (!hit_i || (spans && !line1_valid_i));

    // ask for the high line before the pc needs it
    assign fill_want_hi_o = hit_i && !line1_valid_i && leaves_lo;

    // nop while stalled or misaligned
    always_comb begin
        inst_o       = INST_NOP;
        compressed_o = 1'b0;
        if (!misaligned_o && !stall_o) begin
            compressed_o = is_comp;
            if (is_comp) begin
                inst_o = {16'h0000, cur_parcel};
            end else begin
                inst_o = {nxt_parcel, cur_parcel};
            end
        end
    end

endmodule

`default_nettype wire

// File: src/fetch_unit_top.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_unit_top (
    input  wire                     clk,
    input  wire                     rst,
    input  wire  fetch_pkg::addr_t  pc_i,
    input  wire                     flush_i,
    input  wire                     mem_rvalid_i,
    input  wire  fetch_pkg::line_t  mem_rdata_i,
    output logic [31:0]             inst_o,
    output logic                    compressed_o,
    output logic                    stall_o,
    output logic                    misaligned_o,
    output logic                    mem_req_o,
    output logic [31:0]             mem_addr_o
);

    import fetch_pkg::*;

    line_t line0;
    line_t line1;
    logic  line1_valid;
    addr_t base;
    logic  hit;
    logic  miss;
    logic  fill_lo;
    logic  fill_hi;
    addr_t fill_base;
    logic  fill_want_hi;

    fetch_line_buffer u_buf (
        .clk           (clk),
        .rst           (rst),
        .flush_i       (flush_i),
        .pc_i          (pc_i),
        .fill_lo_i     (fill_lo),
        .fill_hi_i     (fill_hi),
        .fill_base_i   (fill_base),
        .fill_data_i   (mem_rdata_i),
        .line0_o       (line0),
        .line1_o       (line1),
        .line1_valid_o (line1_valid),
        .base_o        (base),
        .hit_o         (hit),
        .miss_o        (miss)
    );

    fetch_ctrl u_ctrl (
        .clk            (clk),
        .rst            (rst),
        .flush_i        (flush_i),
        .pc_i           (pc_i),
        .miss_i         (miss),
        .fill_want_hi_i (fill_want_hi),
        .misaligned_i   (misaligned_o),
        .mem_rvalid_i   (mem_rvalid_i),
        .mem_rdata_i    (mem_rdata_i),
        .base_i         (base),
        .mem_req_o      (mem_req_o),
        .mem_addr_o     (mem_addr_o),
        .fill_lo_o      (fill_lo),
        .fill_hi_o      (fill_hi),
        .fill_base_o    (fill_base)
    );

    inst_aligner u_align (
        .clk_unused_guard_n (1'b1),
        .pc_i               (pc_i),
        .hit_i              (hit),
        .line0_i            (line0),
        .line1_i            (line1),
        .line1_valid_i      (line1_valid),
        .inst_o             (inst_o),
        .compressed_o       (compressed_o),
        .stall_o            (stall_o),
        .fill_want_hi_o     (fill_want_hi),
        .misaligned_o       (misaligned_o)
    );

endmodule

`default_nettype wire

// File: tb/fetch_vectors.svh
`ifndef FETCH_VECTORS_SVH
`define FETCH_VECTORS_SVH

// columns: start pc, flush with a decoy read in flight, expected kind
// span rows move forward to the next offset 6 holding a 32-bit start
localparam int NUM_ROWS = 20;

localparam row_t ROWS [NUM_ROWS] = '{
    '{32'h0000_0000, 1'b0, KIND_ALIGNED},
    '{32'h0000_0002, 1'b0, KIND_ALIGNED},
    '{32'h0000_0004, 1'b0, KIND_ALIGNED},
    '{32'h0000_0006, 1'b0, KIND_SPAN},
    '{32'h0000_008e, 1'b0, KIND_SPAN},
    '{32'h0000_0040, 1'b0, KIND_SEQ},
    '{32'h0000_0100, 1'b0, KIND_ALIGNED},
    '{32'h0000_0106, 1'b0, KIND_SPAN},
    '{32'h0000_0122, 1'b0, KIND_SEQ},
    '{32'h0000_00f0, 1'b1, KIND_FLUSH},
    '{32'h0000_0003, 1'b0, KIND_ODD},
    '{32'h0000_0004, 1'b0, KIND_ALIGNED},
    '{32'h0000_01a6, 1'b1, KIND_FLUSH},
    '{32'h0000_01a7, 1'b0, KIND_ODD},
    '{32'h0000_0080, 1'b0, KIND_SEQ},
    '{32'h0000_00c6, 1'b0, KIND_SPAN},
    '{32'h0000_01c0, 1'b0, KIND_SEQ},
    '{32'h0000_005a, 1'b1, KIND_FLUSH},
    '{32'h0000_0039, 1'b0, KIND_ODD},
    '{32'h0000_013c, 1'b0, KIND_ALIGNED}
};

`endif

// File: tb/fetch_unit_tb.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_unit_tb;

    import fetch_pkg::*;

    // what a table row exercises
    typedef enum logic [2:0] {
        KIND_ALIGNED,
        KIND_SPAN,
        KIND_SEQ,
        KIND_FLUSH,
        KIND_ODD
    } kind_e;

    typedef struct packed {
        addr_t pc;
        logic  flush;
        kind_e kind;
    } row_t;

    `include "fetch_vectors.svh"

    // instructions walked by one sequential row
    localparam int SEQ_LEN = 12;

    logic  clk = 1'b0;
    logic  rst;
    addr_t pc_i;
    logic  flush_i;
    logic  mem_rvalid_i = 1'b0;
    line_t mem_rdata_i = '0;

    inst_t inst_o;
    logic  compressed_o;
    logic  stall_o;
    logic  misaligned_o;
    logic  mem_req_o;
    addr_t mem_addr_o;

    // 64 lines of program memory
    line_t       image [64];
    logic [31:0] lfsr_q = 32'h21c2;
    logic [31:0] dly_bits;

    // responder state
    logic [2:0] rsp_wait = 3'd0;
    addr_t      rsp_addr = '0;
    int         req_count = 0;

    int test_errs;
    int pass_count;
    int fail_count;

    fetch_unit_top UUT (
        .clk          (clk),
        .rst          (rst),
        .pc_i         (pc_i),
        .flush_i      (flush_i),
        .mem_rvalid_i (mem_rvalid_i),
        .mem_rdata_i  (mem_rdata_i),
        .inst_o       (inst_o),
        .compressed_o (compressed_o),
        .stall_o      (stall_o),
        .misaligned_o (misaligned_o),
        .mem_req_o    (mem_req_o),
        .mem_addr_o   (mem_addr_o)
    );

    always #50 clk = ~clk;

    // galois form with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    // one lfsr step per bit taken and msb first
    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    task automatic fill_image();
        logic [31:0] v;
        for (int l = 0; l < 64; l++) begin
            for (int p = 0; p < 4; p++) begin
                take_bits(16, v);
                image[l][p*16 +: 16] = v[15:0];
            end
        end
    endtask

    // halfword of the image at a byte address
    function automatic parcel_t parcel_at(input addr_t a);
        line_t l;
        l = image[a[8:3]];
        return l[a[2:1]*16 +: 16];
    endfunction

    // first offset-6 slot from start on that opens a 32-bit instruction
    function automatic addr_t find_span(input addr_t start);
        addr_t   a;
        parcel_t p;
        a = {start[31:3], 3'b110};
        p = parcel_at(a);
        while (p[1:0] != 2'b11 && a[8:3] < 6'd62) begin
            a = a + 8;
            p = parcel_at(a);
        end
        return a;
    endfunction

    task automatic check_inst(input inst_t got, input inst_t exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, what, got, exp);
            test_errs++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s, got %b, expected %b", $time, what, got, exp);
            test_errs++;
        end
    endtask

    // read port model with 1 to 4 cycles of latency
    always @(posedge clk) begin
        mem_rvalid_i <= 1'b0;
        if (rsp_wait == 3'd1) begin
            mem_rvalid_i <= 1'b1;
            mem_rdata_i  <= image[rsp_addr[8:3]];
        end
        if (rsp_wait != 3'd0) begin
            rsp_wait <= rsp_wait - 3'd1;
        end
        if (mem_req_o) begin
            // reads are whole lines and never overlap
            check_flag(mem_addr_o[2:0] != 3'd0, 1'b0, "read address not line aligned");
            check_flag(rsp_wait != 3'd0 || mem_rvalid_i, 1'b0,
                       "read request with a read outstanding");
            take_bits(2, dly_bits);
            rsp_addr  <= mem_addr_o;
            rsp_wait  <= 3'(dly_bits[1:0]) + 3'd1;
            req_count <= req_count + 1;
        end
    end

    // present one pc and wait out the stall before comparing with the image
    task automatic fetch_pc(input addr_t pc, output logic exp_comp);
        inst_t   exp_inst;
        parcel_t lo;
        lo = parcel_at(pc);
        if (pc[0]) begin
            exp_comp = 1'b0;
            exp_inst = INST_NOP;
        end else if (lo[1:0] != 2'b11) begin
            exp_comp = 1'b1;
            exp_inst = {16'h0000, lo};
        end else begin
            exp_comp = 1'b0;
            exp_inst = {parcel_at(pc + 2), lo};
        end
        @(posedge clk);
        pc_i <= pc;
        @(negedge clk);
        if (pc[0]) begin
            // odd pc never stalls
            check_flag(stall_o, 1'b0, $sformatf("stall_o at pc %h", pc));
        end else begin
            while (stall_o) begin
                @(negedge clk);
            end
        end
        check_flag(misaligned_o, pc[0], $sformatf("misaligned_o at pc %h", pc));
        check_flag(compressed_o, exp_comp, $sformatf("compressed_o at pc %h", pc));
        check_inst(inst_o, exp_inst, $sformatf("inst_o at pc %h", pc));
    endtask

    // decoy refill far away and then a redirect with a flush while it is in flight
    task automatic flush_to(input addr_t pc);
        @(posedge clk);
        pc_i <= pc ^ 32'h100;
        repeat (2) @(posedge clk);
        pc_i    <= pc;
        flush_i <= 1'b1;
        @(posedge clk);
        flush_i <= 1'b0;
    endtask

    task automatic run_row(input int i);
        addr_t pc;
        logic  comp;
        int    reqs;
        kind_e kind;
        test_errs = 0;
        pc = ROWS[i].pc;
        kind = ROWS[i].kind;
        if (ROWS[i].flush) begin
            flush_to(pc);
        end
        case (kind)
            KIND_SEQ: begin
                for (int n = 0; n < SEQ_LEN; n++) begin
                    fetch_pc(pc, comp);
                    pc = pc + (comp ? 32'd2 : 32'd4);
                end
            end
            KIND_SPAN: begin
                pc = find_span(pc);
                fetch_pc(pc, comp);
            end
            KIND_ODD: begin
                fetch_pc(pc, comp);
                // one cycle for a decision made on the old pc
                @(negedge clk);
                reqs = req_count;
                for (int n = 0; n < 4; n++) begin
                    @(negedge clk);
                    check_flag(stall_o, 1'b0, "stall_o while pc is odd");
                end
                check_flag(req_count != reqs, 1'b0, "read request while pc is odd");
            end
            default: begin
                fetch_pc(pc, comp);
            end
        endcase
        if (test_errs == 0) begin
            pass_count++;
        end else begin
            fail_count++;
        end
        $display("test %0d %s pc %h: %s", i, kind.name(), pc,
                 (test_errs == 0) ? "pass" : "fail");
    endtask

    // whole run bounded by the table length
    initial begin
        repeat (NUM_ROWS * 40) @(posedge clk);
        $display("timeout: table not finished within %0d cycles", NUM_ROWS * 40);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        rst        = 1'b1;
        pc_i       = '0;
        flush_i    = 1'b0;
        pass_count = 0;
        fail_count = 0;
        fill_image();
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end
        $display("tests passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+tb
src/fetch_pkg.sv
src/fetch_line_buffer.sv
src/fetch_ctrl.sv
src/inst_aligner.sv
src/fetch_unit_top.sv
tb/fetch_unit_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = fetch_unit_tb
FILELIST  = vlog.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)
